/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_iob2axi
FILELIST = project.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* dv/axi_slave_model.sv */
`timescale 1ns/1ps

module axi_slave_model #(
   parameter int ADDR_W    = 32,
   parameter int DATA_W    = 32,
   parameter int MEM_BYTES = 1024
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   stall_aw,
   input  logic                   stall_w,
   input  logic                   stall_ar,
   input  logic                   stall_r,
   input  logic                   stall_b,
   input  logic [ADDR_W-1:0]      awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [DATA_W-1:0]      wdata,
   input  logic [DATA_W/8-1:0]    wstrb,
   input  logic                   wlast,
   input  logic                   wvalid,
   output logic                   wready,
   output iob2axi_pkg::axi_resp_t bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [ADDR_W-1:0]      araddr,
   input  iob2axi_pkg::axi_len_t  arlen,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [DATA_W-1:0]      rdata,
   output iob2axi_pkg::axi_resp_t rresp,
   output logic                   rlast,
   output logic                   rvalid,
   input  logic                   rready
);
   import iob2axi_pkg::*;

   localparam int STRB_W = DATA_W / 8;
   localparam int MEM_AW = $clog2(MEM_BYTES);

   logic [7:0]        mem [MEM_BYTES];
   logic              w_busy;
   logic              w_resp;
   logic              w_err;
   logic [ADDR_W-1:0] w_addr;
   logic              r_busy;
   logic              r_err;
   logic [ADDR_W-1:0] r_addr;
   axi_len_t          r_len;
   axi_len_t          r_cnt;

   function automatic logic [MEM_AW-1:0] mem_idx(input logic [ADDR_W-1:0] a);
      return a[MEM_AW-1:0];
   endfunction

   function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] w;
      for (int b = 0; b < STRB_W; b++) begin
         w[8*b +: 8] = mem[mem_idx(a + ADDR_W'(b))];
      end
      return w;
   endfunction

   // Fill pattern mixes all address bits
   initial begin
      for (int i = 0; i < MEM_BYTES; i++) begin
         mem[i] = 8'((i * 7) ^ (i >> 3));
      end
   end

   assign awready = !w_busy && !w_resp && !stall_aw;
   assign wready  = w_busy && !stall_w;
   assign arready = !r_busy && !stall_ar;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         w_busy <= 1'b0;
         w_resp <= 1'b0;
         w_err  <= 1'b0;
         w_addr <= '0;
         bvalid <= 1'b0;
         bresp  <= AXI_RESP_OKAY;
      end else begin
         if (awvalid && awready) begin
            w_busy <= 1'b1;
            w_addr <= awaddr;
            w_err  <= awaddr[ADDR_W-1];
         end
         if (wvalid && wready) begin
            w_addr <= w_addr + ADDR_W'(STRB_W);
            if (wlast) begin
               w_busy <= 1'b0;
               w_resp <= 1'b1;
            end
         end
         // Once raised, bvalid holds until bready
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            w_resp <= 1'b0;
         end else if (w_resp && !bvalid && !stall_b) begin
            bvalid <= 1'b1;
            bresp  <= w_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
         end
      end
   end

   // Error region drops writes
   always @(posedge clk) begin
      if (wvalid && wready && !w_err) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
               mem[mem_idx(w_addr + ADDR_W'(b))] <= wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         r_busy <= 1'b0;
         r_err  <= 1'b0;
         r_addr <= '0;
         r_len  <= '0;
         r_cnt  <= '0;
         rvalid <= 1'b0;
         rlast  <= 1'b0;
         rdata  <= '0;
         rresp  <= AXI_RESP_OKAY;
      end else begin
         if (arvalid && arready) begin
            r_busy <= 1'b1;
            r_addr <= araddr;
            r_len  <= arlen;
            r_cnt  <= '0;
            r_err  <= araddr[ADDR_W-1];
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            r_addr <= r_addr + ADDR_W'(STRB_W);
            r_cnt  <= r_cnt + 1'b1;
            if (rlast) begin
               r_busy <= 1'b0;
            end
         end else if (r_busy && !rvalid && !stall_r) begin
            rvalid <= 1'b1;
            rdata  <= read_word(r_addr);
            rlast  <= (r_cnt == r_len);
            rresp  <= r_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
         end
      end
   end

endmodule

/* dv/tb_iob2axi.sv */
`timescale 1ns/1ps

module tb_iob2axi;
   import iob2axi_pkg::*;

   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int STRB_W      = DATA_W / 8;
   localparam int MEM_BYTES   = 1024;
   localparam int MEM_AW      = $clog2(MEM_BYTES);
   localparam int N_BURSTS    = 60;
   localparam int N_DIRECTED  = 5;
   // One burst in 2**ERR_BITS goes to the error region
   localparam int ERR_BITS    = 3;
   // Each stall input is set one cycle in 2**STALL_BITS
   localparam int STALL_BITS  = 2;
   localparam int WATCHDOG_NS = (N_BURSTS + N_DIRECTED) * 16 * 8 * 40;

   logic                clk;
   logic                rst_n;
   axi_len_t            length;
   logic                ready;
   logic                error;
   logic                s_valid;
   logic [ADDR_W-1:0]   s_addr;
   logic [DATA_W-1:0]   s_wdata;
   logic [STRB_W-1:0]   s_wstrb;
   logic [DATA_W-1:0]   s_rdata;
   logic                s_ready;
   logic [ADDR_W-1:0]   m_araddr;
   axi_len_t            m_arlen;
   logic [1:0]          m_arburst;
   logic                m_arvalid;
   logic                m_arready;
   logic [DATA_W-1:0]   m_rdata;
   axi_resp_t           m_rresp;
   logic                m_rlast;
   logic                m_rvalid;
   logic                m_rready;
   logic [ADDR_W-1:0]   m_awaddr;
   axi_len_t            m_awlen;
   logic [1:0]          m_awburst;
   logic                m_awvalid;
   logic                m_awready;
   logic [DATA_W-1:0]   m_wdata;
   logic [STRB_W-1:0]   m_wstrb;
   logic                m_wlast;
   logic                m_wvalid;
   logic                m_wready;
   axi_resp_t           m_bresp;
   logic                m_bvalid;
   logic                m_bready;
   logic                stall_aw;
   logic                stall_w;
   logic                stall_ar;
   logic                stall_r;
   logic                stall_b;

   logic [31:0]         lfsr = 32'hca38;
   logic [7:0]          shadow [MEM_BYTES];
   logic [ADDR_W-1:0]   exp_addr;
   axi_len_t            exp_len;
   int                  w_cnt;
   logic                aw_seen;
   logic                ar_seen;
   logic                exp_wr_err;
   logic                exp_rd_err;

   iob2axi #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut0 (.*);

   axi_slave_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .MEM_BYTES(MEM_BYTES)) slave0 (
      .clk(clk), .rst_n(rst_n),
      .stall_aw(stall_aw), .stall_w(stall_w), .stall_ar(stall_ar),
      .stall_r(stall_r), .stall_b(stall_b),
      .awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
      .wdata(m_wdata), .wstrb(m_wstrb), .wlast(m_wlast), .wvalid(m_wvalid),
      .wready(m_wready), .bresp(m_bresp), .bvalid(m_bvalid), .bready(m_bready),
      .araddr(m_araddr), .arlen(m_arlen), .arvalid(m_arvalid), .arready(m_arready),
      .rdata(m_rdata), .rresp(m_rresp), .rlast(m_rlast), .rvalid(m_rvalid),
      .rready(m_rready)
   );

   always #20 clk = ~clk;

   // Galois LFSR, one step per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic logic [MEM_AW-1:0] mem_idx(input logic [ADDR_W-1:0] a);
      return a[MEM_AW-1:0];
   endfunction

   function automatic logic [DATA_W-1:0] shadow_word(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] w;
      for (int b = 0; b < STRB_W; b++) begin
         w[8*b +: 8] = shadow[mem_idx(a + ADDR_W'(b))];
      end
      return w;
   endfunction

   task automatic stop_run();
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic check_data(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %h actual %h", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_strb(input string what, input logic [STRB_W-1:0] exp,
                             input logic [STRB_W-1:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b actual %b", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_addr(input string what, input logic [ADDR_W-1:0] exp,
                             input logic [ADDR_W-1:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %h actual %h", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_len(input string what, input axi_len_t exp, input axi_len_t act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %0d actual %0d", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_resp(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b actual %b", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b actual %b", $time, what, exp, act);
         stop_run();
      end
   endtask

   // Slave stalls change after the stimulus, so the LFSR order is fixed
   always @(posedge clk) begin : stall_drive
      #2;
      stall_aw = (rand_bits(STALL_BITS) == 0);
      stall_w  = (rand_bits(STALL_BITS) == 0);
      stall_ar = (rand_bits(STALL_BITS) == 0);
      stall_r  = (rand_bits(STALL_BITS) == 0);
      stall_b  = (rand_bits(STALL_BITS) == 0);
   end

   // AXI side monitor
   always @(posedge clk) begin
      if (rst_n) begin
         if (m_awvalid && m_awready) begin
            aw_seen = 1'b1;
            check_addr("awaddr", exp_addr, m_awaddr);
            check_len("awlen", exp_len, m_awlen);
            check_flag("awburst is INCR", 1'b1, m_awburst == 2'b01);
         end
         if (m_wvalid && m_wready) begin
            check_flag("wlast", w_cnt == int'(exp_len), m_wlast);
            // Each W beat carries the native beat driven for it
            check_data("wdata", s_wdata, m_wdata);
            check_strb("wstrb", s_wstrb, m_wstrb);
            w_cnt = w_cnt + 1;
         end
         if (m_arvalid && m_arready) begin
            ar_seen = 1'b1;
            check_addr("araddr", exp_addr, m_araddr);
            check_len("arlen", exp_len, m_arlen);
            check_flag("arburst is INCR", 1'b1, m_arburst == 2'b01);
         end
      end
   end

   task automatic wait_accept();
      @(posedge clk);
      while (!s_ready) begin
         @(posedge clk);
      end
   endtask

   task automatic wait_idle();
      @(posedge clk);
      while (!ready) begin
         @(posedge clk);
      end
   endtask

   task automatic do_write(input logic [ADDR_W-1:0] addr, input axi_len_t len);
      logic [31:0]       r;
      logic [DATA_W-1:0] d;
      logic [STRB_W-1:0] st;
      logic              err;
      err      = addr[ADDR_W-1];
      exp_addr = addr;
      exp_len  = len;
      w_cnt    = 0;
      aw_seen  = 1'b0;
      length   = len;
      for (int i = 0; i <= int'(len); i++) begin
         d = rand_bits(DATA_W);
         r = rand_bits(STRB_W);
         st = r[STRB_W-1:0];
         // A write beat needs at least one strobe bit
         if (st == '0) begin
            st = STRB_W'(1);
         end
         s_valid = 1'b1;
         s_addr  = addr + ADDR_W'(STRB_W * i);
         s_wdata = d;
         s_wstrb = st;
         wait_accept();
         check_flag("ready during write burst", 1'b0, ready);
         if (!err) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (st[b]) begin
                  shadow[mem_idx(s_addr + ADDR_W'(b))] = d[8*b +: 8];
               end
            end
         end
         #1;
      end
      // Strobe stays set so ready follows the write engine
      s_valid = 1'b0;
      wait_idle();
      check_flag("aw handshake seen", 1'b1, aw_seen);
      check_len("w beats minus one", len, axi_len_t'(w_cnt - 1));
      exp_wr_err = err;
      check_resp("error after write", exp_wr_err | exp_rd_err, error);
      #1;
   endtask

   task automatic do_read(input logic [ADDR_W-1:0] addr, input axi_len_t len);
      exp_addr = addr;
      exp_len  = len;
      ar_seen  = 1'b0;
      length   = len;
      for (int i = 0; i <= int'(len); i++) begin
         s_valid = 1'b1;
         s_addr  = addr + ADDR_W'(STRB_W * i);
         s_wdata = '0;
         s_wstrb = '0;
         wait_accept();
         check_flag("ready during read burst", 1'b0, ready);
         check_data("read beat", shadow_word(s_addr), s_rdata);
         #1;
      end
      s_valid = 1'b0;
      wait_idle();
      check_flag("ar handshake seen", 1'b1, ar_seen);
      exp_rd_err = addr[ADDR_W-1];
      check_resp("error after read", exp_wr_err | exp_rd_err, error);
      #1;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the bursts did not finish within the allowed time");
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0]       r;
      logic [ADDR_W-1:0] a;
      axi_len_t          len;
      clk        = 1'b0;
      rst_n      = 1'b0;
      length     = '0;
      s_valid    = 1'b0;
      s_addr     = '0;
      s_wdata    = '0;
      s_wstrb    = '0;
      stall_aw   = 1'b0;
      stall_w    = 1'b0;
      stall_ar   = 1'b0;
      stall_r    = 1'b0;
      stall_b    = 1'b0;
      exp_addr   = '0;
      exp_len    = '0;
      w_cnt      = 0;
      aw_seen    = 1'b0;
      ar_seen    = 1'b0;
      exp_wr_err = 1'b0;
      exp_rd_err = 1'b0;
      for (int i = 0; i < MEM_BYTES; i++) begin
         shadow[i] = 8'((i * 7) ^ (i >> 3));
      end
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      check_flag("ready after reset", 1'b1, ready);
      check_resp("error after reset", 1'b0, error);
      check_flag("arvalid after reset", 1'b0, m_arvalid);
      check_flag("awvalid after reset", 1'b0, m_awvalid);
      check_flag("wvalid after reset", 1'b0, m_wvalid);
      check_flag("rready after reset", 1'b0, m_rready);
      check_flag("bready after reset", 1'b0, m_bready);
      #1;
      // Error region then a normal address, for each direction
      do_write(32'h8000_0040, 8'd3);
      do_write(32'h0000_0040, 8'd3);
      do_read(32'h0000_0040, 8'd3);
      do_read(32'h8000_0100, 8'd0);
      do_read(32'h0000_0100, 8'd1);
      for (int n = 0; n < N_BURSTS; n++) begin
         r   = rand_bits(1);
         len = axi_len_t'(rand_bits(4));
         a   = ADDR_W'((rand_bits(8) % 241) * STRB_W);
         if (rand_bits(ERR_BITS) == 0) begin
            a[ADDR_W-1] = 1'b1;
         end
         if (r[0]) begin
            do_write(a, len);
         end else begin
            do_read(a, len);
         end
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* project.f */
verilog/iob2axi_pkg.sv
verilog/axi4_if.sv
verilog/iob2axi_rd.sv
verilog/iob2axi_wr.sv
verilog/iob2axi.sv
dv/axi_slave_model.sv
dv/tb_iob2axi.sv

/* verilog/axi4_if.sv */
`timescale 1ns/1ps

// AXI4 read address and read data channels
interface axi4_rd_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);
   import iob2axi_pkg::*;

   logic [ADDR_W-1:0] araddr;
   axi_len_t          arlen;
   logic [1:0]        arburst;
   logic              arvalid;
   logic              arready;

   logic [DATA_W-1:0] rdata;
   axi_resp_t         rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;

   modport master (
      output araddr, arlen, arburst, arvalid, rready,
      input  arready, rdata, rresp, rlast, rvalid
   );

   modport slave (
      input  araddr, arlen, arburst, arvalid, rready,
      output arready, rdata, rresp, rlast, rvalid
   );
endinterface

// AXI4 write address, write data and write response channels
interface axi4_wr_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);
   import iob2axi_pkg::*;

   logic [ADDR_W-1:0]   awaddr;
   axi_len_t            awlen;
   logic [1:0]          awburst;
   logic                awvalid;
   logic                awready;

   logic [DATA_W-1:0]   wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic                wlast;
   logic                wvalid;
   logic                wready;

   axi_resp_t           bresp;
   logic                bvalid;
   logic                bready;

   modport master (
      output awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready,
      input  awready, wready, bresp, bvalid
   );

   modport slave (
      input  awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready,
      output awready, wready, bresp, bvalid
   );
endinterface

// Native memory port, valid/ready per beat
interface native_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);
   logic                valid;
   logic [ADDR_W-1:0]   addr;
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic [DATA_W-1:0]   rdata;
   logic                ready;

   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );
endinterface

/* verilog/iob2axi.sv */
`timescale 1ns/1ps

module iob2axi #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                   clk,
   input  logic                   rst_n,

   // Control
   input  iob2axi_pkg::axi_len_t  length,
   output logic                   ready,
   output logic                   error,

   // Native slave port
   input  logic                   s_valid,
   input  logic [ADDR_W-1:0]      s_addr,
   input  logic [DATA_W-1:0]      s_wdata,
   input  logic [DATA_W/8-1:0]    s_wstrb,
   output logic [DATA_W-1:0]      s_rdata,
   output logic                   s_ready,

   // AXI4 master, read side
   output logic [ADDR_W-1:0]      m_araddr,
   output iob2axi_pkg::axi_len_t  m_arlen,
   output logic [1:0]             m_arburst,
   output logic                   m_arvalid,
   input  logic                   m_arready,
   input  logic [DATA_W-1:0]      m_rdata,
   input  iob2axi_pkg::axi_resp_t m_rresp,
   input  logic                   m_rlast,
   input  logic                   m_rvalid,
   output logic                   m_rready,

   // AXI4 master, write side
   output logic [ADDR_W-1:0]      m_awaddr,
   output iob2axi_pkg::axi_len_t  m_awlen,
   output logic [1:0]             m_awburst,
   output logic                   m_awvalid,
   input  logic                   m_awready,
   output logic [DATA_W-1:0]      m_wdata,
   output logic [DATA_W/8-1:0]    m_wstrb,
   output logic                   m_wlast,
   output logic                   m_wvalid,
   input  logic                   m_wready,
   input  iob2axi_pkg::axi_resp_t m_bresp,
   input  logic                   m_bvalid,
   output logic                   m_bready
);

   logic has_strb;
   logic rd_ready;
   logic wr_ready;
   logic rd_error;
   logic wr_error;

   axi4_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi_rd ();
   axi4_wr_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) axi_wr ();
   native_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) rd_nat ();
   native_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) wr_nat ();

   // Any strobe bit set means a write request
   assign has_strb = |s_wstrb;

   assign rd_nat.valid = s_valid && !has_strb;
   assign rd_nat.addr  = s_addr;
   assign rd_nat.wdata = s_wdata;
   assign rd_nat.wstrb = s_wstrb;

   assign wr_nat.valid = s_valid && has_strb;
   assign wr_nat.addr  = s_addr;
   assign wr_nat.wdata = s_wdata;
   assign wr_nat.wstrb = s_wstrb;

   // The idle engine holds its s_ready high, the busy one decides
   assign s_ready = rd_nat.ready && wr_nat.ready;
   assign s_rdata = rd_nat.rdata;
   assign ready   = has_strb ? wr_ready : rd_ready;
   assign error   = rd_error || wr_error;

   assign m_araddr       = axi_rd.araddr;
   assign m_arlen        = axi_rd.arlen;
   assign m_arburst      = axi_rd.arburst;
   assign m_arvalid      = axi_rd.arvalid;
   assign m_rready       = axi_rd.rready;
   assign axi_rd.arready = m_arready;
   assign axi_rd.rdata   = m_rdata;
   assign axi_rd.rresp   = m_rresp;
   assign axi_rd.rlast   = m_rlast;
   assign axi_rd.rvalid  = m_rvalid;

   assign m_awaddr       = axi_wr.awaddr;
   assign m_awlen        = axi_wr.awlen;
   assign m_awburst      = axi_wr.awburst;
   assign m_awvalid      = axi_wr.awvalid;
   assign m_wdata        = axi_wr.wdata;
   assign m_wstrb        = axi_wr.wstrb;
   assign m_wlast        = axi_wr.wlast;
   assign m_wvalid       = axi_wr.wvalid;
   assign m_bready       = axi_wr.bready;
   assign axi_wr.awready = m_awready;
   assign axi_wr.wready  = m_wready;
   assign axi_wr.bresp   = m_bresp;
   assign axi_wr.bvalid  = m_bvalid;

   iob2axi_rd #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) iob2axi_rd0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .length (length),
      .ready  (rd_ready),
      .error  (rd_error),
      .nat    (rd_nat),
      .m      (axi_rd)
   );

   iob2axi_wr #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) iob2axi_wr0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .length (length),
      .ready  (wr_ready),
      .error  (wr_error),
      .nat    (wr_nat),
      .m      (axi_wr)
   );

endmodule

/* verilog/iob2axi_pkg.sv */
package iob2axi_pkg;

   // AXI4 burst length field, beats minus one
   localparam int AXI_LEN_W = 8;

   typedef logic [AXI_LEN_W-1:0] axi_len_t;

   // RRESP and BRESP encoding
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
   localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

   // Only incrementing bursts are issued
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // Shared by both engines, the read side never enters RESP
   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      RESP
   } burst_state_t;

endpackage

/* verilog/iob2axi_rd.sv */
`timescale 1ns/1ps

module iob2axi_rd #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  iob2axi_pkg::axi_len_t length,
   output logic                  ready,
   output logic                  error,
   native_if.slave               nat,
   axi4_rd_if.master             m
);
   import iob2axi_pkg::*;

   // Full width beats only, so low address bits are dropped
   localparam int OFF_W = $clog2(DATA_W / 8);

   burst_state_t      state;
   burst_state_t      state_nxt;
   logic [ADDR_W-1:0] addr_q;
   axi_len_t          len_q;
   logic              start;
   logic              beat;

   assign start = (state == IDLE) && nat.valid;
   assign beat  = m.rvalid && m.rready;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (nat.valid) begin
               state_nxt = ADDR;
            end
         end
         ADDR: begin
            if (m.arready) begin
               state_nxt = DATA;
            end
         end
         DATA: begin
            // Slave marks the end of the burst
            if (beat && m.rlast) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Burst address and length, taken from the first request
   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= nat.addr;
         len_q  <= length;
      end
   end

   // Sticky over the burst, cleared at the start of the next one
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         error <= 1'b0;
      end else if (start) begin
         error <= 1'b0;
      end else if (beat && (m.rresp != AXI_RESP_OKAY)) begin
         error <= 1'b1;
      end
   end

   assign m.araddr  = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
   assign m.arlen   = len_q;
   assign m.arburst = AXI_BURST_INCR;
   assign m.arvalid = (state == ADDR);
   assign m.rready  = (state == DATA) && nat.valid;

   assign nat.rdata = m.rdata;
   assign ready     = (state == IDLE);

   // Hold off the requester in IDLE only when this engine owns the request
   always_comb begin
      case (state)
         IDLE:    nat.ready = !nat.valid;
         DATA:    nat.ready = m.rvalid;
         default: nat.ready = 1'b0;
      endcase
   end

   a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      m.arvalid && !m.arready |=> m.arvalid && $stable(m.araddr) && $stable(m.arlen));

   // rready drops once the last beat is taken
   a_rready_data: assert property (@(posedge clk) disable iff (!rst_n)
      m.rvalid && m.rready && m.rlast |=> !m.rready);

endmodule

/* verilog/iob2axi_wr.sv */
`timescale 1ns/1ps

module iob2axi_wr #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  iob2axi_pkg::axi_len_t length,
   output logic                  ready,
   output logic                  error,
   native_if.slave               nat,
   axi4_wr_if.master             m
);
   import iob2axi_pkg::*;

   // Full width beats only, so low address bits are dropped
   localparam int OFF_W = $clog2(DATA_W / 8);

   burst_state_t      state;
   burst_state_t      state_nxt;
   logic [ADDR_W-1:0] addr_q;
   axi_len_t          len_q;
   axi_len_t          beat_cnt;
   logic              start;
   logic              beat;

   assign start = (state == IDLE) && nat.valid;
   assign beat  = m.wvalid && m.wready;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (nat.valid) begin
               state_nxt = ADDR;
            end
         end
         ADDR: begin
            if (m.awready) begin
               state_nxt = DATA;
            end
         end
         DATA: begin
            if (beat && m.wlast) begin
               state_nxt = RESP;
            end
         end
         RESP: begin
            if (m.bvalid) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= nat.addr;
         len_q  <= length;
      end
   end

   // Counts accepted W beats, drives wlast
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_cnt <= '0;
      end else if (start) begin
         beat_cnt <= '0;
      end else if (beat) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // Error comes from B only, cleared when the next burst starts
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         error <= 1'b0;
      end else if (start) begin
         error <= 1'b0;
      end else if ((state == RESP) && m.bvalid) begin
         error <= (m.bresp != AXI_RESP_OKAY);
      end
   end

   assign m.awaddr  = {addr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
   assign m.awlen   = len_q;
   assign m.awburst = AXI_BURST_INCR;
   assign m.awvalid = (state == ADDR);

   // W beats pass straight through from the native port
   assign m.wvalid  = (state == DATA) && nat.valid;
   assign m.wdata   = nat.wdata;
   assign m.wstrb   = nat.wstrb;
   assign m.wlast   = (state == DATA) && (beat_cnt == len_q);
   assign m.bready  = (state == RESP);

   // Write path returns no data
   assign nat.rdata = '0;
   assign ready     = (state == IDLE);

   always_comb begin
      case (state)
         IDLE:    nat.ready = !nat.valid;
         DATA:    nat.ready = m.wready;
         default: nat.ready = 1'b0;
      endcase
   end

   // No W beat follows the one that carries wlast
   a_wvalid_data: assert property (@(posedge clk) disable iff (!rst_n)
      m.wvalid && m.wready && m.wlast |=> !m.wvalid);

   // Count starts at zero for each burst, so wlast falls on beat number length
   a_wlast_len: assert property (@(posedge clk) disable iff (!rst_n)
      m.awvalid |-> (beat_cnt == '0));

   a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      m.awvalid && !m.awready |=> m.awvalid && $stable(m.awaddr) && $stable(m.awlen));

endmodule
